// ==== logic/rst_pkg.sv ====
`default_nettype none

package rst_pkg;

   //////////////////////////////////////////////////////////////////////
   // Watchdog state and counter types
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      WD_HOLD,
      WD_WAIT,
      WD_PULSE,
      WD_READY,
      WD_FAILED
   } wd_state_e;

   // Retries of a single channel
   typedef logic [3:0] retry_cnt_t;

   // Retries summed over all channels, saturating
   typedef logic [15:0] retry_total_t;

   //////////////////////////////////////////////////////////////////////
   // Default parameter values
   //////////////////////////////////////////////////////////////////////

   localparam int DEF_N_CHAN        = 4;
   localparam int DEF_LOCK_STABLE   = 1024;
   localparam int DEF_CALIB_TIMEOUT = 1 << 20;
   // Reset low time of one retry
   localparam int DEF_RST_PULSE     = 16;
   localparam int DEF_MAX_RETRY     = 3;

endpackage

`default_nettype wire

// ==== logic/chan_status_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Status of one channel, from its watchdog to the collector
interface chan_status_if
   import rst_pkg::*;
();

   // Levels
   logic       ready;
   logic       failed;

   // One cycle high per reset pulse started
   logic       retry_strobe;

   retry_cnt_t retries;
   wd_state_e  state;

   modport wd (
      output ready,
      output failed,
      output retry_strobe,
      output retries,
      output state
   );

   // No back-pressure, strobes are taken as they come
   modport coll (
      input ready,
      input failed,
      input retry_strobe,
      input retries,
      input state
   );

endinterface

`default_nettype wire

// ==== logic/lock_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

// Qualifies the PLL lock level before any channel leaves reset
module lock_filter
   import rst_pkg::*;
#(
   parameter int LOCK_STABLE = DEF_LOCK_STABLE
) (
   input  logic clk_100m,
   input  logic sys_rst_n,
   input  logic pll_locked,
   output logic lock_ok
);

   localparam int STABLE_W = $clog2(LOCK_STABLE + 1);

   logic                lock_meta;
   logic                lock_sync;
   logic [STABLE_W-1:0] stable_cnt;

   //////////////////////////////////////////////////////////////////////
   // Two-flop synchronizer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_100m) begin
      if (!sys_rst_n) begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end else begin
         lock_meta <= pll_locked;
         lock_sync <= lock_meta;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stable counter
   //////////////////////////////////////////////////////////////////////

   // Counts consecutive high cycles, holds once lock is accepted
   always_ff @(posedge clk_100m) begin
      if (!sys_rst_n) begin
         stable_cnt <= '0;
         lock_ok    <= 1'b0;
      end else if (!lock_sync) begin
         // Any low cycle restarts qualification
         stable_cnt <= '0;
         lock_ok    <= 1'b0;
      end else if (stable_cnt == STABLE_W'(LOCK_STABLE - 1)) begin
         lock_ok <= 1'b1;
      end else begin
         stable_cnt <= stable_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/calib_watchdog.sv ====
`timescale 1ns/100ps
`default_nettype none

// Per-channel DDR calibration watchdog with retry limit
module calib_watchdog
   import rst_pkg::*;
#(
   parameter int CALIB_TIMEOUT = DEF_CALIB_TIMEOUT,
   parameter int RST_PULSE     = DEF_RST_PULSE,
   parameter int MAX_RETRY     = DEF_MAX_RETRY
) (
   input  logic      clk_100m,
   input  logic      sys_rst_n,
   input  logic      lock_ok,
   input  logic      calib_done,
   output logic      rst_ddr_n,
   chan_status_if.wd status
);

   localparam int TIMER_W = $clog2(CALIB_TIMEOUT + 1);
   localparam int PULSE_W = $clog2(RST_PULSE + 1);

   wd_state_e          state;
   logic [TIMER_W-1:0] timer;
   logic [PULSE_W-1:0] pulse_cnt;
   retry_cnt_t         retries;
   logic               timeout;
   logic               pulse_end;

   // Last cycle of the calibration window
   assign timeout   = (timer == TIMER_W'(CALIB_TIMEOUT - 1));
   // Last low cycle of a retry pulse
   assign pulse_end = (pulse_cnt == PULSE_W'(RST_PULSE - 1));

   //////////////////////////////////////////////////////////////////////
   // State machine
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_100m) begin
      if (!sys_rst_n) begin
         state     <= WD_HOLD;
         timer     <= '0;
         pulse_cnt <= '0;
         retries   <= '0;
      end else if (!lock_ok) begin
         // Lock lost, start over from hold
         state     <= WD_HOLD;
         timer     <= '0;
         pulse_cnt <= '0;
         retries   <= '0;
      end else begin
         case (state)
            WD_HOLD: begin
               state   <= WD_WAIT;
               timer   <= '0;
               retries <= '0;
            end

            WD_WAIT: begin
               if (calib_done) begin
                  state <= WD_READY;
               end else if (timeout) begin
                  timer <= '0;
                  if (retries < retry_cnt_t'(MAX_RETRY)) begin
                     state     <= WD_PULSE;
                     pulse_cnt <= '0;
                     retries   <= retries + 1'b1;
                  end else begin
                     state <= WD_FAILED;
                  end
               end else begin
                  timer <= timer + 1'b1;
               end
            end

            WD_PULSE: begin
               if (pulse_end) begin
                  state <= WD_WAIT;
                  timer <= '0;
               end else begin
                  pulse_cnt <= pulse_cnt + 1'b1;
               end
            end

            // Terminal until lock drops
            WD_READY, WD_FAILED: begin
               state <= state;
            end

            default: begin
               state <= WD_HOLD;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Outputs
   //////////////////////////////////////////////////////////////////////

   // Controller runs only while waiting or ready
   assign rst_ddr_n = (state == WD_WAIT) || (state == WD_READY);

   assign status.ready        = (state == WD_READY);
   assign status.failed       = (state == WD_FAILED);
   // First cycle of each pulse
   assign status.retry_strobe = (state == WD_PULSE) && (pulse_cnt == '0);
   assign status.retries      = retries;
   assign status.state        = state;

endmodule

`default_nettype wire

// ==== logic/status_collector.sv ====
`timescale 1ns/100ps
`default_nettype none

// Gathers per-channel watchdog status into summary flags
module status_collector
   import rst_pkg::*;
#(
   parameter int N_CHAN = DEF_N_CHAN
) (
   input  logic              clk_100m,
   input  logic              sys_rst_n,
   input  logic              lock_ok,
   chan_status_if.coll       chan [N_CHAN],
   output logic [N_CHAN-1:0] ready_mask,
   output logic              all_ready,
   output logic              any_failed,
   output retry_total_t      retry_total
);

   localparam int STROBE_W = $clog2(N_CHAN + 1);
   localparam int TOTAL_W  = $bits(retry_total_t);
   localparam int SUM_W    = TOTAL_W + 1;

   logic [N_CHAN-1:0]   ready_vec;
   logic [N_CHAN-1:0]   failed_vec;
   logic [N_CHAN-1:0]   strobe_vec;
   logic [STROBE_W-1:0] strobe_cnt;
   logic [SUM_W-1:0]    total_sum;
   retry_total_t        total_next;

   // Flatten the interface array
   for (genvar i = 0; i < N_CHAN; i++) begin : gather_g
      assign ready_vec[i]  = chan[i].ready;
      assign failed_vec[i] = chan[i].failed;
      assign strobe_vec[i] = chan[i].retry_strobe;
   end

   // Strobes seen this cycle
   always_comb begin
      strobe_cnt = '0;
      for (int i = 0; i < N_CHAN; i++) begin
         strobe_cnt = strobe_cnt + STROBE_W'(strobe_vec[i]);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Saturating retry total
   //////////////////////////////////////////////////////////////////////

   assign total_sum  = {1'b0, retry_total} + SUM_W'(strobe_cnt);
   // Carry out means the total hit its ceiling
   assign total_next = total_sum[TOTAL_W] ? '1 : total_sum[TOTAL_W-1:0];

   always_ff @(posedge clk_100m) begin
      if (!sys_rst_n) begin
         ready_mask  <= '0;
         all_ready   <= 1'b0;
         any_failed  <= 1'b0;
         retry_total <= '0;
      end else begin
         ready_mask <= ready_vec;
         all_ready  <= &ready_vec;
         any_failed <= |failed_vec;
         if (!lock_ok) begin
            retry_total <= '0;
         end else begin
            retry_total <= total_next;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/ddr_reset_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

// Reset manager for several DDR channels on clk_100m
module ddr_reset_manager
   import rst_pkg::*;
#(
   parameter int N_CHAN        = DEF_N_CHAN,
   parameter int LOCK_STABLE   = DEF_LOCK_STABLE,
   parameter int CALIB_TIMEOUT = DEF_CALIB_TIMEOUT,
   parameter int RST_PULSE     = DEF_RST_PULSE,
   parameter int MAX_RETRY     = DEF_MAX_RETRY
) (
   input  logic              clk_100m,
   input  logic              sys_rst_n,
   input  logic              pll_locked,
   input  logic [N_CHAN-1:0] calib_done,
   output logic [N_CHAN-1:0] rst_ddr_n,
   output logic [N_CHAN-1:0] ready_mask,
   output logic              all_ready,
   output logic              any_failed,
   output retry_total_t      retry_total
);

   logic lock_ok;

   // One status bundle per channel
   chan_status_if chan_if [N_CHAN] ();

   //////////////////////////////////////////////////////////////////////
   // Lock qualification
   //////////////////////////////////////////////////////////////////////

   lock_filter #(
      .LOCK_STABLE (LOCK_STABLE)
   ) lock_filter_i (
      .clk_100m   (clk_100m),
      .sys_rst_n  (sys_rst_n),
      .pll_locked (pll_locked),
      .lock_ok    (lock_ok)
   );

   //////////////////////////////////////////////////////////////////////
   // Channel watchdogs
   //////////////////////////////////////////////////////////////////////

   for (genvar c = 0; c < N_CHAN; c++) begin : chan_g
      calib_watchdog #(
         .CALIB_TIMEOUT (CALIB_TIMEOUT),
         .RST_PULSE     (RST_PULSE),
         .MAX_RETRY     (MAX_RETRY)
      ) watchdog_i (
         .clk_100m   (clk_100m),
         .sys_rst_n  (sys_rst_n),
         .lock_ok    (lock_ok),
         .calib_done (calib_done[c]),
         .rst_ddr_n  (rst_ddr_n[c]),
         .status     (chan_if[c])
      );
   end

   // Summary flags, one cycle behind the watchdogs
   status_collector #(
      .N_CHAN (N_CHAN)
   ) collector_i (
      .clk_100m    (clk_100m),
      .sys_rst_n   (sys_rst_n),
      .lock_ok     (lock_ok),
      .chan        (chan_if),
      .ready_mask  (ready_mask),
      .all_ready   (all_ready),
      .any_failed  (any_failed),
      .retry_total (retry_total)
   );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// Testbench clock and power-on reset
module clk_gen #(
   parameter int HALF_PERIOD = 5,
   parameter int RST_CYCLES  = 4
) (
   output logic clk_100m,
   output logic sys_rst_n
);

   initial begin
      clk_100m = 1'b0;
      forever #(HALF_PERIOD) clk_100m = ~clk_100m;
   end

   // Released on a rising edge after the hold time
   initial begin
      sys_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_100m);
      sys_rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== bench/ddr_reset_manager_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

// Reset sequencing properties of the DDR reset manager
module ddr_reset_manager_assertions
   import rst_pkg::*;
#(
   parameter int N_CHAN    = DEF_N_CHAN,
   parameter int RST_PULSE = DEF_RST_PULSE
) (
   input logic              clk_100m,
   input logic              sys_rst_n,
   input logic              lock_ok,
   input logic [N_CHAN-1:0] rst_ddr_n,
   chan_status_if.coll      chan [N_CHAN]
);

   // Watchdogs act on lock_ok one edge later
   no_release_unlocked_a : assert property (
      @(posedge clk_100m) disable iff (!sys_rst_n)
      !lock_ok |=> (rst_ddr_n == '0)
   ) else $error("reset released without qualified lock");

   for (genvar c = 0; c < N_CHAN; c++) begin : chan_g
      logic pulse_armed;
      int   low_cnt;

      // Low cycles since the retry strobe
      always_ff @(posedge clk_100m) begin
         if (!sys_rst_n || !lock_ok) begin
            pulse_armed <= 1'b0;
            low_cnt     <= 0;
         end else if (chan[c].retry_strobe) begin
            pulse_armed <= 1'b1;
            low_cnt     <= 1;
         end else if (pulse_armed && !rst_ddr_n[c]) begin
            low_cnt <= low_cnt + 1;
         end else begin
            pulse_armed <= 1'b0;
         end
      end

      pulse_width_a : assert property (
         @(posedge clk_100m) disable iff (!sys_rst_n || !lock_ok)
         (pulse_armed && rst_ddr_n[c]) |-> (low_cnt == RST_PULSE)
      ) else $error("retry pulse width wrong on channel %0d", c);

      // Each retry strobe carries the incremented count
      retry_step_a : assert property (
         @(posedge clk_100m) disable iff (!sys_rst_n || !lock_ok)
         chan[c].retry_strobe |->
            (chan[c].retries == retry_cnt_t'($past(chan[c].retries) + 1'b1))
      ) else $error("retry count did not step on channel %0d", c);

      failed_held_a : assert property (
         @(posedge clk_100m) disable iff (!sys_rst_n)
         (chan[c].failed && lock_ok) |=>
            ((chan[c].state == WD_FAILED) && !rst_ddr_n[c])
      ) else $error("failed channel %0d left reset", c);
   end

endmodule

bind ddr_reset_manager ddr_reset_manager_assertions #(
   .N_CHAN    (N_CHAN),
   .RST_PULSE (RST_PULSE)
) assertions_i (
   .clk_100m  (clk_100m),
   .sys_rst_n (sys_rst_n),
   .lock_ok   (lock_ok),
   .rst_ddr_n (rst_ddr_n),
   .chan      (chan_if)
);

`default_nettype wire

// ==== bench/tb_ddr_reset_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ddr_reset_manager
   import rst_pkg::*;
();

   localparam int N_CHAN        = 4;
   localparam int LOCK_STABLE   = 16;
   localparam int CALIB_TIMEOUT = 64;
   localparam int RST_PULSE     = 8;
   localparam int MAX_RETRY     = 3;
   localparam int SCENARIOS     = 3;
   // Lock time plus every retry window, with margin
   localparam int CYCLE_LIMIT   = 2 * SCENARIOS * (LOCK_STABLE + 2 +
                                  (MAX_RETRY + 1) * (CALIB_TIMEOUT + RST_PULSE) + 100);

   typedef struct packed {
      retry_cnt_t retries;
      logic       failed;
      logic       ready;
   } chan_exp_t;

   logic              clk_100m;
   logic              sys_rst_n;
   logic              pll_locked = 1'b0;
   logic [N_CHAN-1:0] calib_done = '0;
   logic [N_CHAN-1:0] rst_ddr_n;
   logic [N_CHAN-1:0] ready_mask;
   logic              all_ready;
   logic              any_failed;
   retry_total_t      retry_total;

   // Responder and monitor state
   int                need [N_CHAN];
   int                delay_val [N_CHAN];
   int                rel_cnt [N_CHAN];
   int                delay_left [N_CHAN];
   int                low_run [N_CHAN];
   retry_cnt_t        pulses [N_CHAN];
   logic [N_CHAN-1:0] held_low;
   logic [N_CHAN-1:0] rst_prev;
   logic              resp_clear = 1'b1;

   int                cycle_cnt = 0;
   int                check_cnt = 0;
   int                check_kind = 0;
   event              do_compare;
   event              compare_done;

   clk_gen clk_gen_i (
      .clk_100m  (clk_100m),
      .sys_rst_n (sys_rst_n)
   );

   ddr_reset_manager #(
      .N_CHAN        (N_CHAN),
      .LOCK_STABLE   (LOCK_STABLE),
      .CALIB_TIMEOUT (CALIB_TIMEOUT),
      .RST_PULSE     (RST_PULSE),
      .MAX_RETRY     (MAX_RETRY)
   ) dut_i (
      .clk_100m    (clk_100m),
      .sys_rst_n   (sys_rst_n),
      .pll_locked  (pll_locked),
      .calib_done  (calib_done),
      .rst_ddr_n   (rst_ddr_n),
      .ready_mask  (ready_mask),
      .all_ready   (all_ready),
      .any_failed  (any_failed),
      .retry_total (retry_total)
   );

   //////////////////////////////////////////////////////////////////////
   // Reference model and compare tasks
   //////////////////////////////////////////////////////////////////////

   function automatic chan_exp_t expected_chan(int n, int max_retry);
      chan_exp_t e;
      e.retries = retry_cnt_t'((n < max_retry) ? n : max_retry);
      e.failed  = (n > max_retry);
      e.ready   = !e.failed;
      return e;
   endfunction

   task automatic check_retry(string sig, retry_cnt_t exp_v, retry_cnt_t act_v);
      check_cnt++;
      if (act_v !== exp_v) begin
         $display("ERR %0t %s expected %0d actual %0d", $time, sig, exp_v, act_v);
         $display("Verification failed");
         $fatal(1, "retry count mismatch");
      end
   endtask

   task automatic check_total(string sig, retry_total_t exp_v, retry_total_t act_v);
      check_cnt++;
      if (act_v !== exp_v) begin
         $display("ERR %0t %s expected %0d actual %0d", $time, sig, exp_v, act_v);
         $display("Verification failed");
         $fatal(1, "retry total mismatch");
      end
   endtask

   task automatic check_flag(string sig, logic exp_v, logic act_v);
      check_cnt++;
      if (act_v !== exp_v) begin
         $display("ERR %0t %s expected %b actual %b", $time, sig, exp_v, act_v);
         $display("Verification failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic compare_idle(logic after_short_lock);
      for (int c = 0; c < N_CHAN; c++) begin
         check_flag($sformatf("rst_ddr_n[%0d]", c), 1'b0, rst_ddr_n[c]);
         check_flag($sformatf("ready_mask[%0d]", c), 1'b0, ready_mask[c]);
         if (after_short_lock) begin
            check_flag($sformatf("released[%0d]", c), 1'b0, rel_cnt[c] != 0);
         end
      end
      check_flag("all_ready", 1'b0, all_ready);
      check_flag("any_failed", 1'b0, any_failed);
      check_total("retry_total", '0, retry_total);
   endtask

   task automatic compare_scenario();
      chan_exp_t    e;
      retry_total_t exp_total;
      logic         exp_failed;
      logic         exp_all;
      exp_total  = '0;
      exp_failed = 1'b0;
      exp_all    = 1'b1;
      for (int c = 0; c < N_CHAN; c++) begin
         e = expected_chan(need[c], MAX_RETRY);
         check_retry($sformatf("pulses[%0d]", c), e.retries, pulses[c]);
         check_flag($sformatf("ready_mask[%0d]", c), e.ready, ready_mask[c]);
         // Ready channels run, failed ones stay in reset
         check_flag($sformatf("rst_ddr_n[%0d]", c), e.ready, rst_ddr_n[c]);
         exp_total  = exp_total + retry_total_t'(e.retries);
         exp_failed = exp_failed | e.failed;
         exp_all    = exp_all & e.ready;
      end
      check_total("retry_total", exp_total, retry_total);
      check_flag("any_failed", exp_failed, any_failed);
      check_flag("all_ready", exp_all, all_ready);
   endtask

   task automatic run_compare(int kind);
      check_kind = kind;
      -> do_compare;
      @(compare_done);
   endtask

   // Samples on the falling edge, away from DUT updates
   always begin
      @(do_compare);
      @(negedge clk_100m);
      if (check_kind == 2) begin
         compare_scenario();
      end else begin
         compare_idle(check_kind == 1);
      end
      -> compare_done;
   end

   //////////////////////////////////////////////////////////////////////
   // Calibration responders
   //////////////////////////////////////////////////////////////////////

   // Counts releases, answers after the (need+1)-th one
   always @(posedge clk_100m) begin
      for (int c = 0; c < N_CHAN; c++) begin
         if (resp_clear) begin
            rel_cnt[c]     = 0;
            delay_left[c]  = 0;
            low_run[c]     = 0;
            pulses[c]      = '0;
            held_low[c]    = 1'b0;
            calib_done[c] <= 1'b0;
         end else if (rst_ddr_n[c] && !rst_prev[c]) begin
            rel_cnt[c] = rel_cnt[c] + 1;
            low_run[c] = 0;
            if (rel_cnt[c] > 1) begin
               pulses[c] = pulses[c] + 1'b1;
            end
            // Needs beyond the last release never get an answer
            if (rel_cnt[c] == need[c] + 1 && need[c] <= MAX_RETRY) begin
               delay_left[c] = delay_val[c];
            end
         end else if (!rst_ddr_n[c] && rel_cnt[c] > 0) begin
            low_run[c]  = low_run[c] + 1;
            held_low[c] = held_low[c] | (low_run[c] > RST_PULSE + 2);
         end
         if (delay_left[c] > 0) begin
            delay_left[c] = delay_left[c] - 1;
            if (delay_left[c] == 0) begin
               calib_done[c] <= 1'b1;
            end
         end
         rst_prev[c] = rst_ddr_n[c];
      end
   end

   always @(posedge clk_100m) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the channels never settled", cycle_cnt);
         $display("Verification failed");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(71));
      wait (sys_rst_n === 1'b1);
      @(posedge clk_100m);
      run_compare(0);

      // Lock pulse shorter than the stable count
      @(posedge clk_100m);
      resp_clear <= 1'b0;
      pll_locked <= 1'b1;
      repeat (LOCK_STABLE / 2) @(posedge clk_100m);
      pll_locked <= 1'b0;
      repeat (2 * LOCK_STABLE) @(posedge clk_100m);
      run_compare(1);

      for (int s = 0; s < SCENARIOS; s++) begin
         @(posedge clk_100m);
         resp_clear <= 1'b1;
         for (int c = 0; c < N_CHAN; c++) begin
            need[c]      = int'($urandom % 6);
            delay_val[c] = 1 + int'($urandom % 40);
         end
         @(posedge clk_100m);
         resp_clear <= 1'b0;
         pll_locked <= 1'b1;
         // Settled once each channel is ready or stuck in reset
         do begin
            @(negedge clk_100m);
         end while ((ready_mask | held_low) != '1);
         repeat (2) @(negedge clk_100m);
         run_compare(2);
         // Lock lost while channels are up
         @(posedge clk_100m);
         pll_locked <= 1'b0;
         repeat (8) @(posedge clk_100m);
         run_compare(0);
      end

      if (check_cnt > 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("No checks were executed");
         $display("Verification failed");
         $fatal(1, "empty run");
      end
   end

endmodule

`default_nettype wire

// ==== list.f ====
logic/rst_pkg.sv
logic/chan_status_if.sv
logic/lock_filter.sv
logic/calib_watchdog.sv
logic/status_collector.sv
logic/ddr_reset_manager.sv
bench/clk_gen.sv
bench/ddr_reset_manager_assertions.sv
bench/tb_ddr_reset_manager.sv

// ==== Makefile ====
# Verilator flow for the DDR reset manager

VERILATOR  ?= verilator
TB_TOP     ?= tb_ddr_reset_manager
RTL_TOP    ?= ddr_reset_manager
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Verification passed
RTL_FILES  ?= $(shell grep '^logic/' $(FILELIST))
SIM_BIN    := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then exit 0; else exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
